//--- filelist.f
src/rv_isa_pkg.sv
src/core_cfg_pkg.sv
src/bus_if.sv
src/fetch_unit.sv
src/lsu.sv
src/mem_arbiter.sv
src/regfile.sv
src/exec_unit.sv
src/rv_core_top.sv
tb/tb_rv_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_rv_core
FILELIST  = filelist.f
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- tb/core_golden.hex
// Program word count, program words from address 0, store count,
// store triples (word address, data in enabled lanes, strobe), retire count, exit code.
00000035
10000093 80000137 FFD00193 00310233
0040A023 40310233 0040A223 00419213
0040A423 0001A233 0040A623 0051B213
0040A823 0F01C213 0040AA23 00415213
0040AC23 40415213 0040AE23 00116233
0240A023 07F1F213 0240A223 00001217
0240A423 0220A623 00708283 0250A823
00609283 02509B23 0070C283 0250AC23
0060D283 0250AE23 043080A3 0000A283
04509123 00318463 0400A423 00319463
0430A423 0001C463 0400A623 00307463
0420A623 0080036F 0400A823 00C303E7
0400A823 0460A823 0470AA23 02A00513
00100073
00000016
00000100 7FFFFFFD 0000000F
00000104 80000003 0000000F
00000108 FFFFFFD0 0000000F
0000010C 00000001 0000000F
00000110 00000000 0000000F
00000114 FFFFFF0D 0000000F
00000118 08000000 0000000F
0000011C F8000000 0000000F
00000120 80000100 0000000F
00000124 0000007D 0000000F
00000128 0000105C 0000000F
0000012C 80000000 0000000F
00000130 FFFFFF80 0000000F
00000134 80000000 0000000C
00000138 00000080 0000000F
0000013C 00008000 0000000F
00000140 0000FD00 00000002
00000140 FFFD0000 0000000C
00000148 FFFFFFFD 0000000F
0000014C 80000000 0000000F
00000150 000000B8 0000000F
00000154 000000C0 0000000F
00000031
0000002A

//--- tb/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

    logic        clk;
    logic        arst_n;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        mem_rvalid;
    logic [31:0] mem_rdata;
    logic        retire;
    logic [31:0] retire_pc;
    logic        halt;
    logic [31:0] exit_code;

    logic [31:0] golden [0:255];
    logic [31:0] mem [0:255]; // Word addressed, covers 0x000 to 0x3ff.
    logic [31:0] seed;
    logic [31:0] resp_data;
    logic [31:0] fetch_addr;
    logic        fetch_next;
    logic        pending;
    logic        fire;
    int          wait_cnt;
    int          store_idx;
    int          store_count;
    int          store_base;
    int          retire_cnt;

    rv_core_top rv_core_top_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 16;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] strobe_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    // Store check against the golden list, then the write lands in memory.
    task automatic take_store();
        int base;
        logic [31:0] mask;
        if (store_idx >= store_count) begin
            report_failure("The core made more stores than the golden list holds.");
        end
        base = store_base + 3 * store_idx;
        mask = strobe_mask(mem_wstrb);
        check_value("mem_addr", mem_addr, golden[base]);
        check_value("mem_wstrb", {28'b0, mem_wstrb}, golden[base + 2]);
        check_value("mem_wdata", mem_wdata & mask, golden[base + 1]);
        mem[mem_addr[9:2]] = (mem[mem_addr[9:2]] & ~mask) | (mem_wdata & mask);
        store_idx++;
    endtask

    // Memory model with 1 to 4 cycles of random latency.
    always @(posedge clk) begin
        fire = 1'b0;
        if (arst_n) begin
            if (mem_req && pending) begin
                report_failure("A request was issued while a response was outstanding.");
            end
            if (pending) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    fire    = 1'b1;
                    pending = 1'b0;
                end
            end
            if (mem_req) begin
                pending  = 1'b1;
                wait_cnt = 1 + int'(lcg_next() % 4);
                if (mem_we) begin
                    take_store();
                end
                if (fetch_next) begin
                    fetch_addr = mem_addr; // Each instruction opens with its fetch.
                    fetch_next = 1'b0;
                end
                resp_data = mem[mem_addr[9:2]];
            end
            if (retire) begin
                check_value("retire_pc", retire_pc, fetch_addr);
                retire_cnt++;
                fetch_next = 1'b1;
            end
        end
        #1;
        mem_rvalid = fire;
        mem_rdata  = fire ? resp_data : 32'h0;
    end

    initial begin
        int cycles;
        int prog_n;
        clk         = 1'b0;
        arst_n      = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = 32'h0;
        seed        = 32'd88;
        pending     = 1'b0;
        wait_cnt    = 0;
        store_idx   = 0;
        retire_cnt  = 0;
        fetch_addr  = 32'h0;
        fetch_next  = 1'b1;
        $readmemh("tb/core_golden.hex", golden);
        prog_n = int'(golden[0]);
        for (int i = 0; i < 256; i++) begin
            mem[i] = {~i[15:0], i[15:0]} ^ 32'h3c3c_0000;
        end
        for (int i = 0; i < prog_n; i++) begin
            mem[i] = golden[1 + i];
        end
        store_count = int'(golden[1 + prog_n]);
        store_base  = 2 + prog_n;

        repeat (16) begin
            @(posedge clk);
            check_value("mem_req", {31'b0, mem_req}, 32'h0);
            check_value("retire", {31'b0, retire}, 32'h0);
            check_value("halt", {31'b0, halt}, 32'h0);
        end
        #1 arst_n = 1'b1;
        @(posedge clk);
        check_value("mem_req", {31'b0, mem_req}, 32'h0);
        check_value("retire", {31'b0, retire}, 32'h0);
        check_value("halt", {31'b0, halt}, 32'h0);

        // First request must be an instruction read at the reset pc.
        cycles = 0;
        @(posedge clk);
        while (!mem_req) begin
            cycles++;
            if (cycles > 10) begin
                report_failure("The first memory request never came after reset.");
            end
            @(posedge clk);
        end
        check_value("mem_addr", mem_addr, 32'h0);
        check_value("mem_we", {31'b0, mem_we}, 32'h0);

        cycles = 0;
        while (!halt) begin
            @(posedge clk);
            cycles++;
            if (cycles > 5000) begin
                report_failure("The core did not halt within 5000 cycles.");
            end
        end
        check_value("store_count", store_idx, store_count);
        check_value("retire_count", retire_cnt, golden[store_base + 3 * store_count]);
        check_value("exit_code", exit_code, golden[store_base + 3 * store_count + 1]);

        repeat (50) begin
            @(posedge clk);
            check_value("halt", {31'b0, halt}, 32'h1);
            check_value("mem_req", {31'b0, mem_req}, 32'h0);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- src/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top (
    input  logic                            clk,
    input  logic                            arst_n,
    output logic                            mem_req,
    output logic                            mem_we,
    output logic [rv_isa_pkg::xlen-1:0]     mem_addr,
    output logic [rv_isa_pkg::xlen-1:0]     mem_wdata,
    output logic [core_cfg_pkg::strb_w-1:0] mem_wstrb,
    input  logic                            mem_rvalid,
    input  logic [rv_isa_pkg::xlen-1:0]     mem_rdata,
    output logic                            retire,
    output logic [rv_isa_pkg::xlen-1:0]     retire_pc,
    output logic                            halt,
    output logic [rv_isa_pkg::xlen-1:0]     exit_code
);

    logic [rv_isa_pkg::xlen-1:0] pc;
    logic [rv_isa_pkg::xlen-1:0] inst;
    logic                        inst_valid;
    logic                        fetch_start;
    logic                        pc_load;
    logic [rv_isa_pkg::xlen-1:0] next_pc;
    logic                        mem_start;
    logic                        is_store;
    rv_isa_pkg::funct3_e         funct3;
    logic [rv_isa_pkg::xlen-1:0] mem_addr_calc;
    logic [rv_isa_pkg::xlen-1:0] store_data;
    logic [rv_isa_pkg::xlen-1:0] load_data;
    logic                        mem_done;

    fetch_bus_if fetch_bus ();
    data_bus_if  data_bus ();

    fetch_unit fetch_unit_i (
        .clk         (clk          ),
        .arst_n      (arst_n       ),
        .fetch_start (fetch_start  ),
        .pc_load     (pc_load      ),
        .next_pc     (next_pc      ),
        .pc          (pc           ),
        .inst        (inst         ),
        .inst_valid  (inst_valid   ),
        .bus         (fetch_bus    )
    );

    lsu lsu_i (
        .clk         (clk          ),
        .arst_n      (arst_n       ),
        .mem_start   (mem_start    ),
        .is_store    (is_store     ),
        .funct3      (funct3       ),
        .addr        (mem_addr_calc),
        .store_data  (store_data   ),
        .load_data   (load_data    ),
        .mem_done    (mem_done     ),
        .bus         (data_bus     )
    );

    mem_arbiter mem_arbiter_i (
        .clk         (clk          ),
        .arst_n      (arst_n       ),
        .fetch_bus   (fetch_bus    ),
        .data_bus    (data_bus     ),
        .mem_req     (mem_req      ),
        .mem_we      (mem_we       ),
        .mem_addr    (mem_addr     ),
        .mem_wdata   (mem_wdata    ),
        .mem_wstrb   (mem_wstrb    ),
        .mem_rvalid  (mem_rvalid   ),
        .mem_rdata   (mem_rdata    )
    );

    exec_unit exec_unit_i (
        .clk           (clk          ),
        .arst_n        (arst_n       ),
        .pc            (pc           ),
        .inst          (inst         ),
        .inst_valid    (inst_valid   ),
        .load_data     (load_data    ),
        .mem_done      (mem_done     ),
        .fetch_start   (fetch_start  ),
        .pc_load       (pc_load      ),
        .next_pc       (next_pc      ),
        .mem_start     (mem_start    ),
        .is_store      (is_store     ),
        .funct3        (funct3       ),
        .mem_addr_calc (mem_addr_calc),
        .store_data    (store_data   ),
        .retire        (retire       ),
        .retire_pc     (retire_pc    ),
        .halt          (halt         ),
        .exit_code     (exit_code    )
    );

endmodule

//--- src/exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [rv_isa_pkg::xlen-1:0] pc,
    input  logic [rv_isa_pkg::xlen-1:0] inst,
    input  logic                        inst_valid,
    input  logic [rv_isa_pkg::xlen-1:0] load_data,
    input  logic                        mem_done,
    output logic                        fetch_start,
    output logic                        pc_load,
    output logic [rv_isa_pkg::xlen-1:0] next_pc,
    output logic                        mem_start,
    output logic                        is_store,
    output rv_isa_pkg::funct3_e         funct3,
    output logic [rv_isa_pkg::xlen-1:0] mem_addr_calc,
    output logic [rv_isa_pkg::xlen-1:0] store_data,
    output logic                        retire,
    output logic [rv_isa_pkg::xlen-1:0] retire_pc,
    output logic                        halt,
    output logic [rv_isa_pkg::xlen-1:0] exit_code
);

    core_cfg_pkg::seq_state_e          state;
    rv_isa_pkg::opcode_e               opcode;
    rv_isa_pkg::alu_op_e               alu_op;
    logic [rv_isa_pkg::xlen-1:0]       imm;
    logic [rv_isa_pkg::xlen-1:0]       op_a;
    logic [rv_isa_pkg::xlen-1:0]       op_b;
    logic [rv_isa_pkg::xlen-1:0]       alu_out;
    logic [rv_isa_pkg::xlen-1:0]       rs1_data;
    logic [rv_isa_pkg::xlen-1:0]       rs2_data;
    logic [rv_isa_pkg::xlen-1:0]       rd_data;
    logic [rv_isa_pkg::reg_addr_w-1:0] rs1_addr;
    logic                              is_load;
    logic                              is_ebreak;
    logic                              writes_rd;
    logic                              take_branch;

    assign opcode    = rv_isa_pkg::opcode_e'(inst[6:0]);
    assign funct3    = rv_isa_pkg::funct3_e'(inst[14:12]);
    assign is_load   = opcode == rv_isa_pkg::op_load;
    assign is_store  = opcode == rv_isa_pkg::op_store;
    assign is_ebreak = inst == rv_isa_pkg::ebreak_inst;
    assign writes_rd = opcode inside {rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc,
                                      rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr,
                                      rv_isa_pkg::op_load, rv_isa_pkg::op_imm,
                                      rv_isa_pkg::op_reg};

    // EBREAK borrows port 1 to read a0.
    assign rs1_addr = is_ebreak ? 5'd10 : inst[19:15];

    always_comb begin
        case (opcode)
            rv_isa_pkg::op_lui,
            rv_isa_pkg::op_auipc:  imm = {inst[31:12], 12'b0};
            rv_isa_pkg::op_jal:    imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            rv_isa_pkg::op_branch: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_isa_pkg::op_store:  imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            default:               imm = {{21{inst[31]}}, inst[30:20]};
        endcase
    end

    always_comb begin
        alu_op = rv_isa_pkg::alu_add; // Address and upper-immediate sums.
        if (opcode == rv_isa_pkg::op_imm || opcode == rv_isa_pkg::op_reg) begin
            case (inst[14:12])
                3'b000:  alu_op = (opcode == rv_isa_pkg::op_reg && inst[30]) ?
                                  rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
                3'b001:  alu_op = rv_isa_pkg::alu_sll;
                3'b010:  alu_op = rv_isa_pkg::alu_slt;
                3'b011:  alu_op = rv_isa_pkg::alu_sltu;
                3'b100:  alu_op = rv_isa_pkg::alu_xor;
                3'b101:  alu_op = inst[30] ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
                3'b110:  alu_op = rv_isa_pkg::alu_or;
                default: alu_op = rv_isa_pkg::alu_and;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            rv_isa_pkg::op_lui:   op_a = '0;
            rv_isa_pkg::op_auipc: op_a = pc;
            default:              op_a = rs1_data;
        endcase
    end

    assign op_b = (opcode == rv_isa_pkg::op_reg) ? rs2_data : imm;

    always_comb begin
        case (alu_op)
            rv_isa_pkg::alu_sub:  alu_out = op_a - op_b;
            rv_isa_pkg::alu_sll:  alu_out = op_a << op_b[4:0];
            rv_isa_pkg::alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_isa_pkg::alu_sltu: alu_out = {31'b0, op_a < op_b};
            rv_isa_pkg::alu_xor:  alu_out = op_a ^ op_b;
            rv_isa_pkg::alu_srl:  alu_out = op_a >> op_b[4:0];
            rv_isa_pkg::alu_sra:  alu_out = $signed(op_a) >>> op_b[4:0];
            rv_isa_pkg::alu_or:   alu_out = op_a | op_b;
            rv_isa_pkg::alu_and:  alu_out = op_a & op_b;
            default:              alu_out = op_a + op_b;
        endcase
    end

    // Branch codes reuse the load width names.
    always_comb begin
        case (funct3)
            rv_isa_pkg::f3_byte:   take_branch = rs1_data == rs2_data;
            rv_isa_pkg::f3_half:   take_branch = rs1_data != rs2_data;
            rv_isa_pkg::f3_byte_u: take_branch = $signed(rs1_data) < $signed(rs2_data);
            rv_isa_pkg::f3_half_u: take_branch = $signed(rs1_data) >= $signed(rs2_data);
            rv_isa_pkg::f3_ltu:    take_branch = rs1_data < rs2_data;
            rv_isa_pkg::f3_geu:    take_branch = rs1_data >= rs2_data;
            default:               take_branch = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_isa_pkg::op_jal:    next_pc = pc + imm;
            rv_isa_pkg::op_jalr:   next_pc = {alu_out[31:1], 1'b0};
            rv_isa_pkg::op_branch: next_pc = take_branch ? pc + imm : pc + 32'd4;
            default:               next_pc = pc + 32'd4;
        endcase
    end

    always_comb begin
        if (is_load) begin
            rd_data = load_data;
        end else if (opcode == rv_isa_pkg::op_jal || opcode == rv_isa_pkg::op_jalr) begin
            rd_data = pc + 32'd4; // Link value.
        end else begin
            rd_data = alu_out;
        end
    end

    assign mem_addr_calc = alu_out;
    assign store_data    = rs2_data;
    assign mem_start     = state == core_cfg_pkg::st_execute && (is_load || is_store);
    assign retire        = state == core_cfg_pkg::st_writeback;
    assign pc_load       = retire && !is_ebreak;
    assign retire_pc     = pc;
    assign halt          = state == core_cfg_pkg::st_halted;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= core_cfg_pkg::st_fetch;
            fetch_start <= 1'b1; // First fetch right out of reset.
            exit_code   <= '0;
        end else begin
            fetch_start <= 1'b0;
            case (state)
                core_cfg_pkg::st_fetch: begin
                    if (inst_valid) begin
                        state <= core_cfg_pkg::st_execute;
                    end
                end
                core_cfg_pkg::st_execute: begin
                    if (is_load || is_store) begin
                        state <= core_cfg_pkg::st_memory;
                    end else begin
                        state       <= core_cfg_pkg::st_writeback;
                        fetch_start <= !is_ebreak;
                    end
                    if (is_ebreak) begin
                        exit_code <= rs1_data;
                    end
                end
                core_cfg_pkg::st_memory: begin
                    if (mem_done) begin
                        state       <= core_cfg_pkg::st_writeback;
                        fetch_start <= 1'b1;
                    end
                end
                core_cfg_pkg::st_writeback: begin
                    state <= is_ebreak ? core_cfg_pkg::st_halted : core_cfg_pkg::st_fetch;
                end
                default: ; // Halted for good.
            endcase
        end
    end

    regfile regfile_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (inst[24:20]),
        .wen      (retire && writes_rd),
        .rd_addr  (inst[11:7]),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

//--- src/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic                              wen,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rd_addr,
    input  logic [rv_isa_pkg::xlen-1:0]       rd_data,
    output logic [rv_isa_pkg::xlen-1:0]       rs1_data,
    output logic [rv_isa_pkg::xlen-1:0]       rs2_data
);

    logic [rv_isa_pkg::xlen-1:0] regs [1:31]; // No storage behind x0.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                            clk,
    input  logic                            arst_n,
    fetch_bus_if.responder                  fetch_bus,
    data_bus_if.responder                   data_bus,
    output logic                            mem_req,
    output logic                            mem_we,
    output logic [rv_isa_pkg::xlen-1:0]     mem_addr,
    output logic [rv_isa_pkg::xlen-1:0]     mem_wdata,
    output logic [core_cfg_pkg::strb_w-1:0] mem_wstrb,
    input  logic                            mem_rvalid,
    input  logic [rv_isa_pkg::xlen-1:0]     mem_rdata
);

    core_cfg_pkg::bus_owner_e owner;

    // The sequencer never raises both requests in one cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            owner <= core_cfg_pkg::own_fetch;
        end else if (data_bus.req) begin
            owner <= core_cfg_pkg::own_data;
        end else if (fetch_bus.req) begin
            owner <= core_cfg_pkg::own_fetch;
        end
    end

    assign mem_req   = fetch_bus.req | data_bus.req;
    assign mem_we    = data_bus.req & data_bus.we;
    assign mem_addr  = data_bus.req ? data_bus.addr : fetch_bus.addr;
    assign mem_wdata = data_bus.wdata;
    assign mem_wstrb = data_bus.req ? data_bus.wstrb : '0; // Fetch is a plain read.

    // Response goes back only to the side that owns the port.
    assign fetch_bus.rvalid = mem_rvalid && owner == core_cfg_pkg::own_fetch;
    assign fetch_bus.rdata  = mem_rdata;
    assign data_bus.rvalid  = mem_rvalid && owner == core_cfg_pkg::own_data;
    assign data_bus.rdata   = mem_rdata;

endmodule

//--- src/lsu.sv
`timescale 1ns/10ps

module lsu (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        mem_start,
    input  logic                        is_store,
    input  rv_isa_pkg::funct3_e         funct3,
    input  logic [rv_isa_pkg::xlen-1:0] addr,
    input  logic [rv_isa_pkg::xlen-1:0] store_data,
    output logic [rv_isa_pkg::xlen-1:0] load_data,
    output logic                        mem_done,
    data_bus_if.requester               bus
);

    logic [1:0]                      off_q;
    rv_isa_pkg::funct3_e             f3_q;
    logic [core_cfg_pkg::strb_w-1:0] strb;
    logic [rv_isa_pkg::xlen-1:0]     lanes;
    logic [rv_isa_pkg::xlen-1:0]     shifted;
    logic [rv_isa_pkg::xlen-1:0]     ext;

    // Replicate the store value into every lane and enable only the addressed ones.
    always_comb begin
        case (funct3)
            rv_isa_pkg::f3_byte: begin
                strb  = 4'b0001 << addr[1:0];
                lanes = {4{store_data[7:0]}};
            end
            rv_isa_pkg::f3_half: begin
                strb  = 4'b0011 << {addr[1], 1'b0};
                lanes = {2{store_data[15:0]}};
            end
            default: begin
                strb  = 4'b1111;
                lanes = store_data;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus.req  <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            bus.req  <= mem_start;
            mem_done <= bus.rvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_start) begin
            bus.we    <= is_store;
            bus.addr  <= {addr[rv_isa_pkg::xlen-1:2], 2'b00}; // Word aligned.
            bus.wdata <= lanes;
            bus.wstrb <= is_store ? strb : '0;
            off_q     <= addr[1:0];
            f3_q      <= funct3;
        end
        if (bus.rvalid) begin
            load_data <= ext;
        end
    end

    // Move the addressed byte or half down to bit 0, then extend.
    always_comb begin
        shifted = bus.rdata >> {off_q, 3'b000};
        case (f3_q)
            rv_isa_pkg::f3_byte:   ext = {{24{shifted[7]}}, shifted[7:0]};
            rv_isa_pkg::f3_half:   ext = {{16{shifted[15]}}, shifted[15:0]};
            rv_isa_pkg::f3_byte_u: ext = {24'b0, shifted[7:0]};
            rv_isa_pkg::f3_half_u: ext = {16'b0, shifted[15:0]};
            default:               ext = shifted;
        endcase
    end

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        fetch_start,
    input  logic                        pc_load,
    input  logic [rv_isa_pkg::xlen-1:0] next_pc,
    output logic [rv_isa_pkg::xlen-1:0] pc,
    output logic [rv_isa_pkg::xlen-1:0] inst,
    output logic                        inst_valid,
    fetch_bus_if.requester              bus
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc         <= core_cfg_pkg::reset_pc;
            bus.req    <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            if (pc_load) begin
                pc <= next_pc;
            end
            bus.req    <= fetch_start;
            inst_valid <= bus.rvalid;
        end
    end

    // Instruction register, held until the next fetch returns.
    always_ff @(posedge clk) begin
        if (bus.rvalid) begin
            inst <= bus.rdata;
        end
    end

    assign bus.addr = pc; // Already updated when pc_load and fetch_start coincide.

endmodule

//--- src/bus_if.sv
`timescale 1ns/10ps

interface fetch_bus_if;

    logic                        req;
    logic [rv_isa_pkg::xlen-1:0] addr;
    logic                        rvalid;
    logic [rv_isa_pkg::xlen-1:0] rdata;

    modport requester (output req, addr, input rvalid, rdata);
    modport responder (input req, addr, output rvalid, rdata);

endinterface

interface data_bus_if;

    logic                            req;
    logic                            we;
    logic [rv_isa_pkg::xlen-1:0]     addr;
    logic [rv_isa_pkg::xlen-1:0]     wdata;
    logic [core_cfg_pkg::strb_w-1:0] wstrb;
    logic                            rvalid; // Read data or write ack.
    logic [rv_isa_pkg::xlen-1:0]     rdata;

    modport requester (output req, we, addr, wdata, wstrb, input rvalid, rdata);
    modport responder (input req, we, addr, wdata, wstrb, output rvalid, rdata);

endinterface

//--- src/core_cfg_pkg.sv
package core_cfg_pkg;

    localparam logic [rv_isa_pkg::xlen-1:0] reset_pc = '0;

    localparam int strb_w = 4;

    typedef enum logic [2:0] {
        st_fetch,
        st_execute,
        st_memory,
        st_writeback,
        st_halted
    } seq_state_e;

    // Side that issued the request now in flight.
    typedef enum logic {
        own_fetch,
        own_data
    } bus_owner_e;

endpackage

//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] ebreak_inst = 32'h0010_0073;

    // Major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011
    } opcode_e;

    // Loads, stores and branches share these codes.
    typedef enum logic [2:0] {
        f3_byte   = 3'b000, // LB, SB, BEQ.
        f3_half   = 3'b001, // LH, SH, BNE.
        f3_word   = 3'b010, // LW, SW.
        f3_byte_u = 3'b100, // LBU, BLT.
        f3_half_u = 3'b101, // LHU, BGE.
        f3_ltu    = 3'b110, // BLTU.
        f3_geu    = 3'b111  // BGEU.
    } funct3_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

endpackage
